//--- rv_pkg.sv
/*
 * Shared widths, encodings and control-word layout for the RV32I decode/execute slice.
 * Opcode values are the RV32I major opcodes. Loads, stores and system opcodes are absent
 * and decode as illegal. Control-word bits 15:14 are spare and always zero.
 */
package rv_pkg;

    localparam int XLEN       = 32;           // Data and address width
    localparam int REG_ADDR_W = 5;            // x0..x31
    localparam int ALU_OP_W   = 4;            // Width of alu_op_e
    localparam int CTRL_W     = 16;           // Decoded control word

    // Major opcodes handled by the slice
    typedef enum logic [6:0] {
        OP     = 7'b0110011,                  // Register-register ALU
        OP_IMM = 7'b0010011,                  // Register-immediate ALU
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011                   // beq .. bgeu
    } opcode_e;

    // ALU operations, carried in the control word
    typedef enum logic [ALU_OP_W-1:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        AND    = 4'd2,
        OR     = 4'd3,
        XOR    = 4'd4,
        SLL    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        SLT    = 4'd8,                        // Signed compare
        SLTU   = 4'd9,                        // Unsigned compare
        PASS_B = 4'd10                        // LUI, operand B straight through
    } alu_op_e;

    // Control-word layout
    // [3:0]   ALU op
    // [4]     B from immediate
    // [5]     A from PC
    // [6]     Write rd
    // [7]     Conditional branch
    // [8]     JAL or JALR
    // [9]     Target from rs1
    // [10]    Illegal
    // [13:11] funct3 for branch conditions
    localparam int CTRL_ALU_LSB    = 0;
    localparam int CTRL_SRC_B_IMM  = 4;
    localparam int CTRL_SRC_A_PC   = 5;
    localparam int CTRL_REG_WRITE  = 6;
    localparam int CTRL_BRANCH     = 7;
    localparam int CTRL_JUMP       = 8;
    localparam int CTRL_JALR       = 9;
    localparam int CTRL_ILLEGAL    = 10;
    localparam int CTRL_FUNCT3_LSB = 11;

endpackage

//--- rv_decoder.sv
/*
 * Combinational RV32I decode into control word, immediate and register addresses.
 * Loads, stores, fence and system opcodes are flagged illegal. So are bad OP funct7 and
 * reserved branch funct3. An illegal instruction has write, branch and jump cleared.
 */
`timescale 1ns/10ps

module rv_decoder (
    input  logic [31:0]                    i_instr,
    output logic [rv_pkg::CTRL_W-1:0]      o_ctrl,
    output logic [31:0]                    o_imm,
    output logic [rv_pkg::REG_ADDR_W-1:0]  o_rs1_addr,
    output logic [rv_pkg::REG_ADDR_W-1:0]  o_rs2_addr,
    output logic [rv_pkg::REG_ADDR_W-1:0]  o_rd_addr
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [31:0]     imm_i, imm_u, imm_j, imm_b;
    rv_pkg::alu_op_e alu_op;
    logic            src_b_imm, src_a_pc, reg_write;
    logic            branch, jump, jalr, illegal;

    // funct3 to ALU op. alt selects SUB / SRA
    function automatic rv_pkg::alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rv_pkg::SUB : rv_pkg::ADD;
            3'b001:  return rv_pkg::SLL;
            3'b010:  return rv_pkg::SLT;
            3'b011:  return rv_pkg::SLTU;
            3'b100:  return rv_pkg::XOR;
            3'b101:  return alt ? rv_pkg::SRA : rv_pkg::SRL;
            3'b110:  return rv_pkg::OR;
            default: return rv_pkg::AND;
        endcase
    endfunction

    assign opcode     = i_instr[6:0];
    assign funct3     = i_instr[14:12];
    assign funct7     = i_instr[31:25];
    assign o_rd_addr  = i_instr[11:7];
    assign o_rs1_addr = i_instr[19:15];
    assign o_rs2_addr = i_instr[24:20];

    // Sign-extended immediates per format
    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
    assign imm_b = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};

    always_comb begin
        alu_op    = rv_pkg::ADD;               // Also serves AUIPC, JALR, branches
        src_b_imm = 1'b0;
        src_a_pc  = 1'b0;
        reg_write = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        jalr      = 1'b0;
        illegal   = 1'b0;
        o_imm     = imm_i;
        case (opcode)
            rv_pkg::OP: begin
                reg_write = 1'b1;
                alu_op    = alu_from_funct3(funct3, funct7[5]);
                if (funct7 == 7'b0100000)  // Only sub and sra use the alternate form
                    illegal = !(funct3 == 3'b000 || funct3 == 3'b101);
                else
                    illegal = (funct7 != 7'b0000000);
            end
            rv_pkg::OP_IMM: begin
                reg_write = 1'b1;
                src_b_imm = 1'b1;
                alu_op    = alu_from_funct3(funct3, i_instr[30] && funct3 == 3'b101); // srai
            end
            rv_pkg::LUI: begin
                reg_write = 1'b1;
                src_b_imm = 1'b1;
                alu_op    = rv_pkg::PASS_B;
                o_imm     = imm_u;
            end
            rv_pkg::AUIPC: begin
                reg_write = 1'b1;
                src_b_imm = 1'b1;
                src_a_pc  = 1'b1;              // pc + imm_u
                o_imm     = imm_u;
            end
            rv_pkg::JAL: begin
                reg_write = 1'b1;              // Link
                jump      = 1'b1;
                o_imm     = imm_j;
            end
            rv_pkg::JALR: begin
                reg_write = 1'b1;
                jump      = 1'b1;
                jalr      = 1'b1;              // Base from rs1, imm_i
            end
            rv_pkg::BRANCH: begin
                branch  = 1'b1;
                illegal = (funct3 == 3'b010 || funct3 == 3'b011); // Reserved conditions
                o_imm   = imm_b;
            end
            default: illegal = 1'b1;           // Loads, stores, fence, system
        endcase
        if (illegal) begin
            reg_write = 1'b0;
            branch    = 1'b0;
            jump      = 1'b0;
        end
    end

    // Pack control word
    always_comb begin
        o_ctrl = '0;
        o_ctrl[rv_pkg::CTRL_ALU_LSB +: rv_pkg::ALU_OP_W] = alu_op;
        o_ctrl[rv_pkg::CTRL_SRC_B_IMM]  = src_b_imm;
        o_ctrl[rv_pkg::CTRL_SRC_A_PC]   = src_a_pc;
        o_ctrl[rv_pkg::CTRL_REG_WRITE]  = reg_write;
        o_ctrl[rv_pkg::CTRL_BRANCH]     = branch;
        o_ctrl[rv_pkg::CTRL_JUMP]       = jump;
        o_ctrl[rv_pkg::CTRL_JALR]       = jalr;
        o_ctrl[rv_pkg::CTRL_ILLEGAL]    = illegal;
        o_ctrl[rv_pkg::CTRL_FUNCT3_LSB +: 3] = funct3;
    end

endmodule

//--- rv_regfile.sv
/*
 * 32 x 32 register file, two combinational reads, one synchronous write.
 * x0 reads zero and ignores writes. A read of the register written this cycle
 * returns the write data. All registers clear on reset.
 */
`timescale 1ns/10ps

module rv_regfile (
    input  logic                           clk,
    input  logic                           i_rst,
    input  logic [rv_pkg::REG_ADDR_W-1:0]  i_rs1_addr,
    input  logic [rv_pkg::REG_ADDR_W-1:0]  i_rs2_addr,
    output logic [rv_pkg::XLEN-1:0]        o_rs1_data,
    output logic [rv_pkg::XLEN-1:0]        o_rs2_data,
    input  logic                           i_wr_en,
    input  logic [rv_pkg::REG_ADDR_W-1:0]  i_wr_addr,
    input  logic [rv_pkg::XLEN-1:0]        i_wr_data
);

    logic [rv_pkg::XLEN-1:0] regs [2**rv_pkg::REG_ADDR_W];

    // One read port, with x0 and write-through bypass
    function automatic logic [rv_pkg::XLEN-1:0] read_port(
        input logic [rv_pkg::REG_ADDR_W-1:0] addr
    );
        if (addr == '0)
            return '0;
        else if (i_wr_en && i_wr_addr == addr)
            return i_wr_data;                  // Fresh result from execute
        else
            return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < 2**rv_pkg::REG_ADDR_W; i++)
                regs[i] <= '0;
        end else if (i_wr_en && i_wr_addr != '0) begin // x0 stays zero
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    always_comb o_rs1_data = read_port(i_rs1_addr);
    always_comb o_rs2_data = read_port(i_rs2_addr);

endmodule

//--- id_ex_reg.sv
/*
 * ID/EX pipeline register. Captures on i_en, holds otherwise.
 * Only the valid bit is reset, so data fields are undefined until the first capture.
 * A bubble (i_valid low) still loads the data fields.
 */
`timescale 1ns/10ps

module id_ex_reg (
    input  logic                           clk,
    input  logic                           i_rst,
    input  logic                           i_en,         // Inverted stall
    input  logic                           i_valid,
    input  logic [rv_pkg::CTRL_W-1:0]      i_ctrl,
    input  logic [rv_pkg::XLEN-1:0]        i_pc,
    input  logic [rv_pkg::XLEN-1:0]        i_rs1_data,
    input  logic [rv_pkg::XLEN-1:0]        i_rs2_data,
    input  logic [rv_pkg::XLEN-1:0]        i_imm,
    input  logic [rv_pkg::REG_ADDR_W-1:0]  i_rd_addr,
    output logic                           o_valid,
    output logic [rv_pkg::CTRL_W-1:0]      o_ctrl,
    output logic [rv_pkg::XLEN-1:0]        o_pc,
    output logic [rv_pkg::XLEN-1:0]        o_rs1_data,
    output logic [rv_pkg::XLEN-1:0]        o_rs2_data,
    output logic [rv_pkg::XLEN-1:0]        o_imm,
    output logic [rv_pkg::REG_ADDR_W-1:0]  o_rd_addr
);

    logic [rv_pkg::XLEN-1:0]       data_q [4];    // pc, rs1, rs2, imm
    logic [rv_pkg::CTRL_W-1:0]     ctrl_q;
    logic [rv_pkg::REG_ADDR_W-1:0] rd_q;
    logic                          valid_q;

    always_ff @(posedge clk) begin
        if (i_rst)
            valid_q <= 1'b0;
        else if (i_en)
            valid_q <= i_valid;                // Bubble when fetch has nothing
    end

    // Payload, no reset
    always_ff @(posedge clk) begin
        if (i_en) begin
            ctrl_q    <= i_ctrl;
            data_q[0] <= i_pc;
            data_q[1] <= i_rs1_data;
            data_q[2] <= i_rs2_data;
            data_q[3] <= i_imm;
            rd_q      <= i_rd_addr;
        end
    end

    assign o_valid    = valid_q;
    assign o_ctrl     = ctrl_q;
    assign o_pc       = data_q[0];
    assign o_rs1_data = data_q[1];
    assign o_rs2_data = data_q[2];
    assign o_imm      = data_q[3];
    assign o_rd_addr  = rd_q;

endmodule

//--- rv_alu.sv
/*
 * Execute stage, purely combinational from the ID/EX contents.
 * Jumps return pc + 4 as result. Branch outcome and target are reported only.
 * Branch compares reuse the ALU operands, which are rs1 and rs2 for branches.
 */
`timescale 1ns/10ps

module rv_alu (
    input  logic                           i_valid,
    input  logic [rv_pkg::CTRL_W-1:0]      i_ctrl,
    input  logic [rv_pkg::XLEN-1:0]        i_pc,
    input  logic [rv_pkg::XLEN-1:0]        i_rs1_data,
    input  logic [rv_pkg::XLEN-1:0]        i_rs2_data,
    input  logic [rv_pkg::XLEN-1:0]        i_imm,
    input  logic [rv_pkg::REG_ADDR_W-1:0]  i_rd_addr,
    output logic                           o_valid,
    output logic                           o_wr_en,
    output logic [rv_pkg::REG_ADDR_W-1:0]  o_rd,
    output logic [rv_pkg::XLEN-1:0]        o_result,
    output logic                           o_branch_taken,
    output logic [rv_pkg::XLEN-1:0]        o_branch_target,
    output logic                           o_illegal
);

    rv_pkg::alu_op_e         alu_op;
    logic [rv_pkg::XLEN-1:0] op_a, op_b, alu_out, target_sum;
    logic [2:0]              funct3;
    logic                    eq, lt, ltu, cond;
    logic                    jump, jalr, illegal;

    assign alu_op  = rv_pkg::alu_op_e'(i_ctrl[rv_pkg::CTRL_ALU_LSB +: rv_pkg::ALU_OP_W]);
    assign funct3  = i_ctrl[rv_pkg::CTRL_FUNCT3_LSB +: 3];
    assign jump    = i_ctrl[rv_pkg::CTRL_JUMP];
    assign jalr    = i_ctrl[rv_pkg::CTRL_JALR];
    assign illegal = i_ctrl[rv_pkg::CTRL_ILLEGAL];

    assign op_a = i_ctrl[rv_pkg::CTRL_SRC_A_PC]  ? i_pc  : i_rs1_data;
    assign op_b = i_ctrl[rv_pkg::CTRL_SRC_B_IMM] ? i_imm : i_rs2_data;

    // Shared compares for SLT/SLTU and branches
    assign eq  = (op_a == op_b);
    assign lt  = ($signed(op_a) < $signed(op_b));
    assign ltu = (op_a < op_b);

    always_comb begin
        case (alu_op)
            rv_pkg::ADD:    alu_out = op_a + op_b;
            rv_pkg::SUB:    alu_out = op_a - op_b;
            rv_pkg::AND:    alu_out = op_a & op_b;
            rv_pkg::OR:     alu_out = op_a | op_b;
            rv_pkg::XOR:    alu_out = op_a ^ op_b;
            rv_pkg::SLL:    alu_out = op_a << op_b[4:0];
            rv_pkg::SRL:    alu_out = op_a >> op_b[4:0];
            rv_pkg::SRA:    alu_out = $signed(op_a) >>> op_b[4:0];
            rv_pkg::SLT:    alu_out = {{(rv_pkg::XLEN-1){1'b0}}, lt};
            rv_pkg::SLTU:   alu_out = {{(rv_pkg::XLEN-1){1'b0}}, ltu};
            default:        alu_out = op_b;    // PASS_B
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  cond = eq;                // beq
            3'b001:  cond = !eq;               // bne
            3'b100:  cond = lt;                // blt
            3'b101:  cond = !lt;               // bge
            3'b110:  cond = ltu;               // bltu
            3'b111:  cond = !ltu;              // bgeu
            default: cond = 1'b0;
        endcase
    end

    assign target_sum      = (jalr ? i_rs1_data : i_pc) + i_imm;
    assign o_branch_target = {target_sum[rv_pkg::XLEN-1:1], target_sum[0] & !jalr};
    assign o_branch_taken  = i_valid && !illegal
                             && (jump || (i_ctrl[rv_pkg::CTRL_BRANCH] && cond));

    assign o_valid   = i_valid;
    assign o_rd      = i_rd_addr;
    assign o_result  = jump ? i_pc + 32'd4 : alu_out; // Link value for jumps
    assign o_illegal = i_valid && illegal;
    assign o_wr_en   = i_valid && i_ctrl[rv_pkg::CTRL_REG_WRITE] && !illegal
                       && (i_rd_addr != '0);

endmodule

//--- rv_decode_execute.sv
/*
 * Decode and execute slice of an RV32I core around the ID/EX register.
 * One cycle from capture to o_valid. Fetch must hold its inputs while i_stall is high.
 * Branch and jump outcomes are reported only; no redirect or flush.
 */
`timescale 1ns/10ps

module rv_decode_execute (
    input  logic                           clk,
    input  logic                           i_rst,
    input  logic                           i_valid,
    input  logic [rv_pkg::XLEN-1:0]        i_instr,
    input  logic [rv_pkg::XLEN-1:0]        i_pc,
    input  logic                           i_stall,
    output logic                           o_valid,
    output logic                           o_wr_en,
    output logic [rv_pkg::REG_ADDR_W-1:0]  o_rd,
    output logic [rv_pkg::XLEN-1:0]        o_result,
    output logic                           o_branch_taken,
    output logic [rv_pkg::XLEN-1:0]        o_branch_target,
    output logic                           o_illegal
);

    // Decode side
    logic [rv_pkg::CTRL_W-1:0]     dec_ctrl;
    logic [rv_pkg::XLEN-1:0]       dec_imm;
    logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr, rs2_addr, dec_rd;
    logic [rv_pkg::XLEN-1:0]       rs1_data, rs2_data;
    // Execute side
    logic                          ex_valid;
    logic [rv_pkg::CTRL_W-1:0]     ex_ctrl;
    logic [rv_pkg::XLEN-1:0]       ex_pc, ex_rs1, ex_rs2, ex_imm;
    logic [rv_pkg::REG_ADDR_W-1:0] ex_rd;
    logic                          rf_wr_en;

    assign rf_wr_en = o_wr_en && !i_stall;     // Write once, at the releasing edge

    rv_decoder u_decoder (
        .i_instr(i_instr), .o_ctrl(dec_ctrl), .o_imm(dec_imm),
        .o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr), .o_rd_addr(dec_rd)
    );

    rv_regfile u_regfile (
        .clk(clk), .i_rst(i_rst),
        .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr),
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data),
        .i_wr_en(rf_wr_en), .i_wr_addr(o_rd), .i_wr_data(o_result)
    );

    id_ex_reg u_id_ex (
        .clk(clk), .i_rst(i_rst), .i_en(!i_stall), .i_valid(i_valid),
        .i_ctrl(dec_ctrl), .i_pc(i_pc), .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
        .i_imm(dec_imm), .i_rd_addr(dec_rd),
        .o_valid(ex_valid), .o_ctrl(ex_ctrl), .o_pc(ex_pc), .o_rs1_data(ex_rs1),
        .o_rs2_data(ex_rs2), .o_imm(ex_imm), .o_rd_addr(ex_rd)
    );

    rv_alu u_alu (
        .i_valid(ex_valid), .i_ctrl(ex_ctrl), .i_pc(ex_pc),
        .i_rs1_data(ex_rs1), .i_rs2_data(ex_rs2), .i_imm(ex_imm), .i_rd_addr(ex_rd),
        .o_valid(o_valid), .o_wr_en(o_wr_en), .o_rd(o_rd), .o_result(o_result),
        .o_branch_taken(o_branch_taken), .o_branch_target(o_branch_target),
        .o_illegal(o_illegal)
    );

endmodule

//--- tb_rv_decode_execute.sv
/*
 * Testbench for the RV32I decode/execute slice. A reference model built from the ISA
 * rules predicts every output one cycle after capture. Inputs change on the falling edge,
 * outputs are checked on the falling edge. Loads and bad funct7 must read as illegal.
 */
`timescale 1ns/10ps

module tb_rv_decode_execute;

    localparam int CLK_PERIOD  = 40;
    localparam int N_RAND      = 150;                   // Random ops per pass
    localparam int TEST_CYCLES = 6 * N_RAND + 600;      // Two passes, one stalled, plus directed

    logic        clk = 1'b0;
    logic        i_rst, i_valid, i_stall;
    logic [31:0] i_instr, i_pc;
    logic        o_valid, o_wr_en, o_branch_taken, o_illegal;
    logic [4:0]  o_rd;
    logic [31:0] o_result, o_branch_target;

    // Reference model
    logic [31:0] ref_regs [32];
    logic        exp_valid = 1'b0;
    logic        exp_wr_en = 1'b0;
    logic        exp_taken = 1'b0;
    logic        exp_illegal = 1'b0;
    logic        exp_writes, exp_has_target;
    logic [4:0]  exp_rd;
    logic [31:0] exp_result, exp_target;

    logic        stall_on;                              // Random back-pressure enable
    logic [31:0] next_pc;
    int          errors = 0;
    int          checks = 0;

    rv_decode_execute dut (
        .clk(clk), .i_rst(i_rst), .i_valid(i_valid), .i_instr(i_instr), .i_pc(i_pc),
        .i_stall(i_stall), .o_valid(o_valid), .o_wr_en(o_wr_en), .o_rd(o_rd),
        .o_result(o_result), .o_branch_taken(o_branch_taken),
        .o_branch_target(o_branch_target), .o_illegal(o_illegal)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Instruction encoders
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    // ISA arithmetic, alt picks sub / sra
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt)
                    return $signed(a) >>> b[4:0];       // Sign bit fills from the top
                else
                    return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_cond(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;                     // beq
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;                      // bltu
            default: return a >= b;
        endcase
    endfunction

    task automatic clear_expect();
        exp_valid      = 1'b0;
        exp_wr_en      = 1'b0;
        exp_taken      = 1'b0;
        exp_illegal    = 1'b0;
        exp_writes     = 1'b0;
        exp_has_target = 1'b0;
    endtask

    // Expected outputs of one instruction, from the ISA definition
    task automatic predict(input logic [31:0] instr, input logic [31:0] pc_in);
        logic [31:0] a, b, imm_i;
        logic [2:0]  f3;
        f3    = instr[14:12];
        a     = ref_regs[instr[19:15]];
        b     = ref_regs[instr[24:20]];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        clear_expect();
        exp_valid = 1'b1;
        exp_rd    = instr[11:7];
        case (instr[6:0])
            7'b0110011: begin                          // OP
                exp_writes  = 1'b1;
                exp_illegal = !(instr[31:25] == 7'h00
                                || (instr[31:25] == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
                exp_result  = alu_ref(f3, instr[30], a, b);
            end
            7'b0010011: begin                          // OP-IMM, only srai has alt
                exp_writes = 1'b1;
                exp_result = alu_ref(f3, instr[30] && f3 == 3'b101, a, imm_i);
            end
            7'b0110111: begin                          // LUI
                exp_writes = 1'b1;
                exp_result = {instr[31:12], 12'b0};
            end
            7'b0010111: begin                          // AUIPC
                exp_writes = 1'b1;
                exp_result = pc_in + {instr[31:12], 12'b0};
            end
            7'b1101111: begin                          // JAL
                exp_writes     = 1'b1;
                exp_taken      = 1'b1;
                exp_has_target = 1'b1;
                exp_result     = pc_in + 32'd4;
                exp_target     = pc_in + {{12{instr[31]}}, instr[19:12], instr[20],
                                          instr[30:21], 1'b0};
            end
            7'b1100111: begin                          // JALR, bit 0 cleared
                exp_writes     = 1'b1;
                exp_taken      = 1'b1;
                exp_has_target = 1'b1;
                exp_result     = pc_in + 32'd4;
                exp_target     = (a + imm_i) & 32'hFFFF_FFFE;
            end
            7'b1100011: begin                          // Conditional branches
                exp_illegal    = (f3 == 3'b010 || f3 == 3'b011);
                exp_has_target = !exp_illegal;
                exp_taken      = !exp_illegal && branch_cond(f3, a, b);
                exp_target     = pc_in + {{20{instr[31]}}, instr[7], instr[30:25],
                                          instr[11:8], 1'b0};
            end
            default: exp_illegal = 1'b1;               // Loads, stores, system
        endcase
        exp_writes = exp_writes && !exp_illegal;
        exp_wr_en  = exp_writes && exp_rd != 5'd0;
    endtask

    // Model steps on every edge the DUT steps
    always @(posedge clk) begin
        if (i_rst) begin
            for (int r = 0; r < 32; r++)
                ref_regs[r] = '0;
            clear_expect();
        end else if (!i_stall) begin
            if (exp_wr_en)
                ref_regs[exp_rd] = exp_result;         // Retire the one in flight
            if (i_valid)
                predict(i_instr, i_pc);
            else
                clear_expect();                        // Bubble
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        checks++;
        assert (act_v === exp_v) else begin
            errors++;
            $display("ERROR at %0t ns: %s expected %h, actual %h", $time, name, exp_v, act_v);
        end
    endtask

    // Outputs settle from the ID/EX register, stable at the falling edge
    always @(negedge clk) begin
        check_value("o_valid", 32'(exp_valid), 32'(o_valid));
        check_value("o_wr_en", 32'(exp_wr_en), 32'(o_wr_en));
        check_value("o_branch_taken", 32'(exp_taken), 32'(o_branch_taken));
        check_value("o_illegal", 32'(exp_illegal), 32'(o_illegal));
        if (exp_valid) begin
            check_value("o_rd", 32'(exp_rd), 32'(o_rd));
            if (exp_writes)
                check_value("o_result", exp_result, o_result);
            if (exp_has_target)
                check_value("o_branch_target", exp_target, o_branch_target);
        end
    end

    // Present one instruction, maybe behind a random stall
    task automatic issue(input logic [31:0] instr);
        logic [1:0] coin;
        @(negedge clk);
        coin    = 2'($urandom());
        i_valid = 1'b1;
        i_instr = instr;
        i_pc    = next_pc;
        i_stall = stall_on && coin == 2'b00;
        while (i_stall) begin
            @(negedge clk);
            i_stall = 1'($urandom());                  // Inputs held meanwhile
        end
        next_pc = next_pc + 32'd4;
    endtask

    task automatic bubble();
        @(negedge clk);
        i_valid = 1'b0;
        i_instr = $urandom();                          // Junk, must be ignored
        i_stall = 1'b0;
    endtask

    task automatic random_ops();
        logic [31:0] bits, imm;
        logic [6:0]  f7;
        logic [11:0] imm12;
        for (int n = 0; n < N_RAND; n++) begin
            bits  = $urandom();
            imm   = $urandom();
            f7    = (bits[18] && (bits[17:15] == 3'b000 || bits[17:15] == 3'b101)) ? 7'h20
                                                                                     : 7'h00;
            imm12 = (bits[16:15] == 2'b01) ? {f7, bits[14:10]} : imm[11:0]; // Shift encoding
            if (bits[31:29] == 3'b000)
                bubble();
            else case (bits[20:19])
                2'd0:    issue(r_type(f7, bits[14:10], bits[9:5], bits[17:15], bits[4:0]));
                2'd1:    issue(i_type(imm12, bits[9:5], bits[17:15], bits[4:0], 7'b0010011));
                2'd2:    issue(u_type(imm[31:12], bits[4:0], 7'b0110111));
                default: issue(u_type(imm[31:12], bits[4:0], 7'b0010111));
            endcase
        end
    endtask

    // Second and third op read the rd just written, through the bypass
    task automatic dependent_pairs();
        for (int n = 0; n < 8; n++) begin
            issue(i_type(12'($urandom()), 5'd0, 3'b000, 5'd7, 7'b0010011));
            issue(r_type(7'h00, 5'd7, 5'd7, 3'b000, 5'd8));
            issue(r_type(7'h20, 5'd7, 5'd8, 3'b000, 5'd9));
        end
        issue(i_type(12'($urandom()), 5'd0, 3'b000, 5'd0, 7'b0010011)); // addi to x0
        issue(r_type(7'h00, 5'd0, 5'd0, 3'b110, 5'd16));                // x0 still zero
    endtask

    task automatic branches_and_jumps();
        logic [2:0]  conds [6];
        logic [12:0] boff;
        conds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        issue(u_type(20'hFFFFF, 5'd10, 7'b0110111));
        issue(i_type(12'h7F0, 5'd10, 3'b000, 5'd10, 7'b0010011)); // x10 negative
        issue(i_type(12'd5, 5'd0, 3'b000, 5'd11, 7'b0010011));    // x11 = 5
        foreach (conds[c]) begin
            boff = {12'($urandom()), 1'b0};
            issue(b_type(boff, 5'd11, 5'd10, conds[c]));
            issue(b_type(boff, 5'd10, 5'd11, conds[c]));          // Swapped operands
            issue(b_type(boff, 5'd10, 5'd10, conds[c]));          // Equal operands
        end
        issue(j_type({20'($urandom()), 1'b0}, 5'd12));
        issue(i_type(12'($urandom()), 5'd10, 3'b000, 5'd13, 7'b1100111)); // Odd sums too
        issue(r_type(7'h00, 5'd13, 5'd12, 3'b000, 5'd14));        // Reads both links
        issue(j_type({20'($urandom()), 1'b0}, 5'd0));             // No link
    endtask

    task automatic illegal_ops();
        issue(i_type(12'($urandom()), 5'd1, 3'b010, 5'd3, 7'b0000011)); // lw
        issue(r_type(7'h00, 5'd0, 5'd3, 3'b000, 5'd17));          // x3 unchanged
        issue(r_type(7'h01, 5'd2, 5'd1, 3'b000, 5'd4));           // Bad funct7
        issue(r_type(7'h00, 5'd0, 5'd4, 3'b000, 5'd18));
    endtask

    initial begin
        void'($urandom(12));
        i_rst    = 1'b1;
        i_valid  = 1'b0;
        i_stall  = 1'b0;
        i_instr  = '0;
        i_pc     = '0;
        stall_on = 1'b0;
        next_pc  = $urandom() & 32'hFFFF_FFFC;
        repeat (5) @(negedge clk);
        i_rst = 1'b0;
        repeat (3) bubble();
        for (int r = 1; r < 32; r++)
            issue(r_type(7'h00, 5'd0, 5'(r), 3'b000, 5'(r)));      // Cleared file reads 0
        for (int r = 1; r < 32; r++) begin
            issue(u_type(20'($urandom()), 5'(r), 7'b0110111));
            issue(i_type(12'($urandom()), 5'(r), 3'b000, 5'(r), 7'b0010011));
        end
        random_ops();
        dependent_pairs();
        branches_and_jumps();
        illegal_ops();
        stall_on = 1'b1;
        random_ops();
        dependent_pairs();
        branches_and_jumps();
        illegal_ops();
        repeat (3) bubble();
        @(negedge clk);
        @(posedge clk);                                 // Last falling-edge checks are done
        $display("Run complete: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    initial begin
        #(TEST_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, stimulus did not finish", TEST_CYCLES);
        $display("tests failed");
        $finish;
    end

endmodule

//--- rv_decode_execute.f
rv_pkg.sv
rv_decoder.sv
rv_regfile.sv
id_ex_reg.sv
rv_alu.sv
rv_decode_execute.sv
tb_rv_decode_execute.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs the decode/execute testbench with Verilator.
# Exit status is 0 only when the pass line shows up in the simulator output.

cd "$(dirname "$0")" || { echo "Cannot enter project root"; exit 1; }

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rv_decode_execute \
    -f rv_decode_execute.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_rv_decode_execute)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "all tests passed"; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1
